/* rtl/dcache_cfg.svh */
// geometry of the L1 data cache memory block
// include wherever the widths below are needed

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// set associativity and line layout
`define DCACHE_WAYS         4
`define DCACHE_WORD_W       32
`define DCACHE_BANKS        4
`define DCACHE_LINE_W       128
`define DCACHE_BE_W         (`DCACHE_WORD_W / 8)

// address split
`define DCACHE_OFF_W        4
`define DCACHE_WORD_OFF_LSB 2
`define DCACHE_BANK_W       (`DCACHE_OFF_W - `DCACHE_WORD_OFF_LSB)
`define DCACHE_IDX_W        6
`define DCACHE_SETS         (1 << `DCACHE_IDX_W)
`define DCACHE_TAG_W        10

// read side
`define DCACHE_RD_PORTS     3
`define DCACHE_PORT_W       2

`endif

/* rtl/dcache_pkg.sv */
// types shared by the stages of the data cache memory block
// import into any module that handles requests, bank accesses or compare context

`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

  // one read port request, the tag follows a cycle later
  typedef struct packed {
    logic [`DCACHE_IDX_W-1:0] idx;
    logic [`DCACHE_OFF_W-1:0] off;
    logic                     tag_only;
    logic                     prio;
  } rd_port_t;

  // full line write from the refill path
  typedef struct packed {
    logic                       vld;
    logic [`DCACHE_WAYS-1:0]    we;
    logic [`DCACHE_TAG_W-1:0]   tag;
    logic [`DCACHE_IDX_W-1:0]   idx;
    logic [`DCACHE_OFF_W-1:0]   off;
    logic [`DCACHE_LINE_W-1:0]  data;
    logic [`DCACHE_LINE_W/8-1:0] be;
    logic [`DCACHE_WAYS-1:0]    vld_bits;
  } line_wr_t;

  // single word write, way given one-hot
  typedef struct packed {
    logic [`DCACHE_WAYS-1:0]   req;
    logic [`DCACHE_IDX_W-1:0]  idx;
    logic [`DCACHE_OFF_W-1:0]  off;
    logic [`DCACHE_WORD_W-1:0] data;
    logic [`DCACHE_BE_W-1:0]   be;
  } word_wr_t;

  typedef enum logic [1:0] {
    bank_idle,
    bank_read,
    bank_word_wr,
    bank_line_wr
  } bank_op_e;

  // access to one data bank, all ways side by side
  typedef struct packed {
    logic                                        req;
    logic                                        we;
    logic [`DCACHE_IDX_W-1:0]                    idx;
    logic [`DCACHE_WAYS-1:0][`DCACHE_BE_W-1:0]   be;
    logic [`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] wdata;
  } bank_req_t;

  typedef struct packed {
    logic                      cmp_en;
    logic [`DCACHE_PORT_W-1:0] port;
    logic [`DCACHE_BANK_W-1:0] word_off;
    logic                      line_wr;
  } cmp_ctx_t;

endpackage

`default_nettype wire

/* rtl/dcache_rr_arbiter.sv */
// read port arbiter: high priority requests mask low priority ones,
// the remaining competitors share a round-robin pointer

`default_nettype none

`include "dcache_cfg.svh"

module dcache_rr_arbiter (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic [`DCACHE_RD_PORTS-1:0]    req_i,
  input  wire logic [`DCACHE_RD_PORTS-1:0]    prio_i,
  input  wire logic                           hold_i,
  output logic      [`DCACHE_RD_PORTS-1:0]    gnt_o,
  output logic      [`DCACHE_PORT_W-1:0]      gnt_idx_o
);

  localparam int NumPorts = `DCACHE_RD_PORTS;
  localparam int PortW    = `DCACHE_PORT_W;

  logic [NumPorts-1:0] req_prio;
  logic [NumPorts-1:0] req_masked;
  logic [PortW-1:0]    rr_ptr_q;
  logic [PortW-1:0]    rr_ptr_d;
  logic                found;

  // only high priority ports compete when any is present
  assign req_prio   = req_i & prio_i;
  assign req_masked = (|req_prio) ? req_prio : req_i;

  // first requester at or after the pointer
  always_comb begin : p_pick
    int cand;
    found     = 1'b0;
    gnt_idx_o = '0;
    for (int i = 0; i < NumPorts; i++) begin
      cand = int'(rr_ptr_q) + i;
      if (cand >= NumPorts) begin
        cand = cand - NumPorts;
      end
      if (!found && req_masked[cand]) begin
        found     = 1'b1;
        gnt_idx_o = PortW'(cand);
      end
    end
  end

  always_comb begin : p_gnt
    gnt_o = '0;
    if (found && !hold_i) begin
      gnt_o[gnt_idx_o] = 1'b1;
    end
  end

  // pointer moves past the winner
  assign rr_ptr_d = (int'(gnt_idx_o) == NumPorts - 1) ? '0 : gnt_idx_o + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else if (|gnt_o) begin
      rr_ptr_q <= rr_ptr_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_sram.sv */
// single-port synchronous RAM with byte lane write enables
// read data shows up one cycle after the request and holds until the next read

`default_nettype none

module dcache_sram #(
  parameter int DataWidth = 32,
  parameter int NumWords  = 64
) (
  input  wire logic                          clk_i,
  input  wire logic                          req_i,
  input  wire logic                          we_i,
  input  wire logic [$clog2(NumWords)-1:0]   addr_i,
  input  wire logic [(DataWidth+7)/8-1:0]    be_i,
  input  wire logic [DataWidth-1:0]          wdata_i,
  output logic      [DataWidth-1:0]          rdata_o
);

  localparam int BeWidth = (DataWidth + 7) / 8;

  logic [DataWidth-1:0] mem [NumWords];
  logic [BeWidth-1:0]   lane_we;

  // a narrow last lane covers the leftover bits
  assign lane_we = be_i & {BeWidth{we_i}};

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < DataWidth; b++) begin
          if (lane_we[b/8]) begin
            mem[addr_i][b] <= wdata_i[b];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_bank_ctrl.sv */
// request stage: arbitrates the read ports and plans the tag array
// and per-bank data accesses for the line write, the read and the word write

`default_nettype none

`include "dcache_cfg.svh"

module dcache_bank_ctrl import dcache_pkg::*; (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic      [`DCACHE_RD_PORTS-1:0]      rd_req_i,
  input  wire rd_port_t  [`DCACHE_RD_PORTS-1:0]      rd_port_i,
  input  wire line_wr_t                              line_wr_i,
  input  wire word_wr_t                              word_wr_i,
  output logic           [`DCACHE_RD_PORTS-1:0]      rd_ack_o,
  output logic                                       wr_ack_o,
  output bank_req_t      [`DCACHE_BANKS-1:0]         bank_o,
  output logic           [`DCACHE_WAYS-1:0]          tag_req_o,
  output logic                                       tag_we_o,
  output logic           [`DCACHE_IDX_W-1:0]         tag_idx_o,
  output cmp_ctx_t                                   ctx_o
);

  logic [`DCACHE_RD_PORTS-1:0] rd_prio;
  logic [`DCACHE_PORT_W-1:0]   gnt_idx;
  logic                        rd_acked;
  logic                        rd_claims;
  rd_port_t                    rd_sel;
  logic [`DCACHE_BANK_W-1:0]   rd_bank;
  logic [`DCACHE_BANK_W-1:0]   wr_bank;
  logic [`DCACHE_BANK_W-1:0]   cl_bank;
  bank_op_e                    bank_op [`DCACHE_BANKS];

  ////////////////////
  // read arbitration
  ////////////////////

  for (genvar k = 0; k < `DCACHE_RD_PORTS; k++) begin : gen_prio
    assign rd_prio[k] = rd_port_i[k].prio;
  end

  // line write holds off every read
  dcache_rr_arbiter u_rr_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (rd_req_i),
    .prio_i    (rd_prio),
    .hold_i    (line_wr_i.vld),
    .gnt_o     (rd_ack_o),
    .gnt_idx_o (gnt_idx)
  );

  assign rd_acked  = |rd_ack_o;
  assign rd_sel    = rd_port_i[gnt_idx];
  assign rd_bank   = rd_sel.off[`DCACHE_OFF_W-1:`DCACHE_WORD_OFF_LSB];
  assign wr_bank   = word_wr_i.off[`DCACHE_OFF_W-1:`DCACHE_WORD_OFF_LSB];
  assign cl_bank   = line_wr_i.off[`DCACHE_OFF_W-1:`DCACHE_WORD_OFF_LSB];
  assign rd_claims = rd_acked & ~rd_sel.tag_only;

  // word write yields only to a read on the same bank
  assign wr_ack_o = (|word_wr_i.req) & ~line_wr_i.vld & ~(rd_claims && rd_bank == wr_bank);

  ////////////////////
  // bank planning
  ////////////////////

  always_comb begin : p_bank_op
    for (int k = 0; k < `DCACHE_BANKS; k++) begin
      if (line_wr_i.vld) begin
        bank_op[k] = bank_line_wr;
      end else if (rd_claims && int'(rd_bank) == k) begin
        bank_op[k] = bank_read;
      end else if (wr_ack_o && int'(wr_bank) == k) begin
        bank_op[k] = bank_word_wr;
      end else begin
        bank_op[k] = bank_idle;
      end
    end
  end

  always_comb begin : p_bank_req
    for (int k = 0; k < `DCACHE_BANKS; k++) begin
      bank_o[k].req = (bank_op[k] != bank_idle);
      bank_o[k].we  = (bank_op[k] == bank_line_wr) || (bank_op[k] == bank_word_wr);
      bank_o[k].idx = word_wr_i.idx;
      bank_o[k].be  = '0;
      for (int j = 0; j < `DCACHE_WAYS; j++) begin
        bank_o[k].wdata[j] = word_wr_i.data;
      end
      case (bank_op[k])
        bank_line_wr: begin
          bank_o[k].idx = line_wr_i.idx;
          for (int j = 0; j < `DCACHE_WAYS; j++) begin
            bank_o[k].be[j]    = line_wr_i.we[j] ?
                                 line_wr_i.be[k*`DCACHE_BE_W +: `DCACHE_BE_W] : '0;
            bank_o[k].wdata[j] = line_wr_i.data[k*`DCACHE_WORD_W +: `DCACHE_WORD_W];
          end
        end
        bank_read: bank_o[k].idx = rd_sel.idx;
        bank_word_wr: begin
          for (int j = 0; j < `DCACHE_WAYS; j++) begin
            bank_o[k].be[j] = word_wr_i.req[j] ? word_wr_i.be : '0;
          end
        end
        default: ;
      endcase
    end
  end

  // tag arrays: all ways on a read, enabled ways on a line write
  assign tag_req_o = line_wr_i.vld ? line_wr_i.we : {`DCACHE_WAYS{rd_acked}};
  assign tag_we_o  = line_wr_i.vld;
  assign tag_idx_o = line_wr_i.vld ? line_wr_i.idx : rd_sel.idx;

  assign ctx_o.cmp_en   = rd_acked;
  assign ctx_o.port     = gnt_idx;
  assign ctx_o.word_off = line_wr_i.vld ? cl_bank : rd_bank;
  assign ctx_o.line_wr  = line_wr_i.vld;

endmodule

`default_nettype wire

/* rtl/dcache_hit_sel.sv */
// compare stage: registers the request context, builds the way-hit vector
// from the late tag and picks the read word, or forwards refill data

`default_nettype none

`include "dcache_cfg.svh"

module dcache_hit_sel import dcache_pkg::*; (
  input  wire logic                                                 clk_i,
  input  wire logic                                                 rst_ni,
  input  wire cmp_ctx_t                                             ctx_i,
  input  wire logic [`DCACHE_RD_PORTS-1:0][`DCACHE_TAG_W-1:0]       rd_tag_i,
  input  wire line_wr_t                                             line_wr_i,
  input  wire logic [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0]           tag_rdata_i,
  input  wire logic [`DCACHE_WAYS-1:0]                              vld_rdata_i,
  input  wire logic [`DCACHE_BANKS-1:0][`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] bank_rdata_i,
  output logic      [`DCACHE_WAYS-1:0]                              rd_hit_oh_o,
  output logic      [`DCACHE_WAYS-1:0]                              rd_vld_bits_o,
  output logic      [`DCACHE_WORD_W-1:0]                            rd_data_o
);

  cmp_ctx_t                                    ctx_q;
  logic [`DCACHE_TAG_W-1:0]                    cmp_tag;
  logic [`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] way_word;
  logic [`DCACHE_WORD_W-1:0]                   hit_word;

  // context of the request whose arrays are read out now
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctx_q <= '0;
    end else begin
      ctx_q <= ctx_i;
    end
  end

  // tag arrives one cycle after the ack of its port
  assign cmp_tag = rd_tag_i[ctx_q.port];

  for (genvar i = 0; i < `DCACHE_WAYS; i++) begin : gen_way
    assign rd_hit_oh_o[i] = ctx_q.cmp_en & vld_rdata_i[i] & (tag_rdata_i[i] == cmp_tag);
    assign way_word[i]    = bank_rdata_i[ctx_q.word_off][i];
  end

  assign rd_vld_bits_o = vld_rdata_i;

  // hit vector is one-hot, so an OR of the gated words selects it
  always_comb begin : p_word_mux
    hit_word = '0;
    for (int i = 0; i < `DCACHE_WAYS; i++) begin
      if (rd_hit_oh_o[i]) begin
        hit_word = hit_word | way_word[i];
      end
    end
  end

  // refill forwarding of the addressed word in the write cycle
  assign rd_data_o = ctx_i.line_wr ?
                     line_wr_i.data[ctx_i.word_off*`DCACHE_WORD_W +: `DCACHE_WORD_W] :
                     hit_word;

endmodule

`default_nettype wire

/* rtl/dcache_mem.sv */
// memory block of the write-through L1 data cache
// request stage, tag/valid and data arrays, and the compare stage

`default_nettype none

`include "dcache_cfg.svh"

module dcache_mem import dcache_pkg::*; (
  input  wire logic                                            clk_i,
  input  wire logic                                            rst_ni,
  // read ports, tag one cycle after the ack
  input  wire logic      [`DCACHE_RD_PORTS-1:0]                rd_req_i,
  input  wire rd_port_t  [`DCACHE_RD_PORTS-1:0]                rd_port_i,
  input  wire logic      [`DCACHE_RD_PORTS-1:0][`DCACHE_TAG_W-1:0] rd_tag_i,
  output logic           [`DCACHE_RD_PORTS-1:0]                rd_ack_o,
  output logic           [`DCACHE_WAYS-1:0]                    rd_hit_oh_o,
  output logic           [`DCACHE_WAYS-1:0]                    rd_vld_bits_o,
  output logic           [`DCACHE_WORD_W-1:0]                  rd_data_o,
  // write ports
  input  wire line_wr_t                                        line_wr_i,
  input  wire word_wr_t                                        word_wr_i,
  output logic                                                 wr_ack_o
);

  bank_req_t [`DCACHE_BANKS-1:0]                            bank_req;
  logic      [`DCACHE_WAYS-1:0]                             tag_req;
  logic                                                     tag_we;
  logic      [`DCACHE_IDX_W-1:0]                            tag_idx;
  cmp_ctx_t                                                 ctx;
  logic      [`DCACHE_WAYS-1:0][`DCACHE_TAG_W:0]            vld_tag_rdata;
  logic      [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0]          tag_rdata;
  logic      [`DCACHE_WAYS-1:0]                             vld_rdata;
  logic      [`DCACHE_BANKS-1:0][`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] bank_rdata;

  ////////////////////
  // request stage
  ////////////////////

  dcache_bank_ctrl u_bank_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_req_i  (rd_req_i),
    .rd_port_i (rd_port_i),
    .line_wr_i (line_wr_i),
    .word_wr_i (word_wr_i),
    .rd_ack_o  (rd_ack_o),
    .wr_ack_o  (wr_ack_o),
    .bank_o    (bank_req),
    .tag_req_o (tag_req),
    .tag_we_o  (tag_we),
    .tag_idx_o (tag_idx),
    .ctx_o     (ctx)
  );

  ////////////////////
  // memory stage
  ////////////////////

  // valid bit sits above the tag in each entry
  for (genvar i = 0; i < `DCACHE_WAYS; i++) begin : gen_tag_ram
    assign tag_rdata[i] = vld_tag_rdata[i][`DCACHE_TAG_W-1:0];
    assign vld_rdata[i] = vld_tag_rdata[i][`DCACHE_TAG_W];

    dcache_sram #(
      .DataWidth (`DCACHE_TAG_W + 1),
      .NumWords  (`DCACHE_SETS)
    ) u_tag_sram (
      .clk_i   (clk_i),
      .req_i   (tag_req[i]),
      .we_i    (tag_we),
      .addr_i  (tag_idx),
      .be_i    ('1),
      .wdata_i ({line_wr_i.vld_bits[i], line_wr_i.tag}),
      .rdata_o (vld_tag_rdata[i])
    );
  end

  // one bank per word offset, all ways side by side
  for (genvar k = 0; k < `DCACHE_BANKS; k++) begin : gen_data_bank
    dcache_sram #(
      .DataWidth (`DCACHE_WAYS * `DCACHE_WORD_W),
      .NumWords  (`DCACHE_SETS)
    ) u_data_sram (
      .clk_i   (clk_i),
      .req_i   (bank_req[k].req),
      .we_i    (bank_req[k].we),
      .addr_i  (bank_req[k].idx),
      .be_i    (bank_req[k].be),
      .wdata_i (bank_req[k].wdata),
      .rdata_o (bank_rdata[k])
    );
  end

  ////////////////////
  // compare stage
  ////////////////////

  dcache_hit_sel u_hit_sel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctx_i         (ctx),
    .rd_tag_i      (rd_tag_i),
    .line_wr_i     (line_wr_i),
    .tag_rdata_i   (tag_rdata),
    .vld_rdata_i   (vld_rdata),
    .bank_rdata_i  (bank_rdata),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
// free-running clock for the testbench
// the period comes from the instantiating module

`default_nettype none

module tb_clkgen #(
  parameter int PeriodNs = 100
) (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* dv/tb_dcache_mem.sv */
// testbench for the data cache memory block
// directed tests checked against an array model of tags, valid bits and data
// build and run through run_sim.sh

`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache_mem import dcache_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int Ways      = `DCACHE_WAYS;
  localparam int Banks     = `DCACHE_BANKS;
  localparam int Ports     = `DCACHE_RD_PORTS;
  localparam int Sets      = `DCACHE_SETS;
  localparam int WordW     = `DCACHE_WORD_W;
  localparam int TagW      = `DCACHE_TAG_W;
  localparam int IdxW      = `DCACHE_IDX_W;
  localparam int OffW      = `DCACHE_OFF_W;
  localparam int BeW       = `DCACHE_BE_W;
  localparam int ClkPeriod = 100;
  localparam int RdTimeout = 8;

  // operation counts of all tests where each op takes three cycles at most
  localparam int LineOps        = 26;
  localparam int ReadOps        = 86;
  localparam int WordOps        = 6;
  localparam int WatchdogCycles = 2 * (8 + 3 * (LineOps + ReadOps + WordOps)) + 100;

  logic                           clk;
  logic                           rst_n;
  logic     [Ports-1:0]           rd_req;
  rd_port_t [Ports-1:0]           rd_port;
  logic     [Ports-1:0][TagW-1:0] rd_tag;
  logic     [Ports-1:0]           rd_ack;
  logic     [Ways-1:0]            rd_hit_oh;
  logic     [Ways-1:0]            rd_vld_bits;
  logic     [WordW-1:0]           rd_data;
  line_wr_t                       line_wr;
  word_wr_t                       word_wr;
  logic                           wr_ack;

  // reference model of the arrays
  logic [TagW-1:0]  m_tag  [Ways][Sets];
  logic             m_vld  [Ways][Sets];
  logic [WordW-1:0] m_data [Ways][Sets][Banks];
  logic [1:0]       rr_ptr;

  // request specs used by the read engine
  logic [IdxW-1:0]  spec_idx   [Ports];
  logic [OffW-1:0]  spec_off   [Ports];
  logic [TagW-1:0]  spec_tag   [Ports];
  logic             spec_prio  [Ports];
  logic             spec_tonly [Ports];
  word_wr_t         spec_wr;

  logic [31:0]      lfsr_q;
  int               fill_sets [4] = '{3, 17, 42, 63};
  int               n_checks = 0;
  int               n_errors = 0;
  int               n_tests = 0;
  int               n_failed = 0;
  int               test_err_start = 0;
  string            test_name;

  tb_clkgen #(.PeriodNs(ClkPeriod)) u_clkgen (.clk_o(clk));

  dcache_mem u_dcache_mem (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .rd_req_i      (rd_req),
    .rd_port_i     (rd_port),
    .rd_tag_i      (rd_tag),
    .rd_ack_o      (rd_ack),
    .rd_hit_oh_o   (rd_hit_oh),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_data_o     (rd_data),
    .line_wr_i     (line_wr),
    .word_wr_i     (word_wr),
    .wr_ack_o      (wr_ack)
  );

  ////////////////////
  // helpers
  ////////////////////

  // fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // low tag bits carry the way so tags in a set never collide
  function automatic logic [TagW-1:0] new_tag(input int way);
    return TagW'({rand_bits(TagW - 2), 2'(way)});
  endfunction

  function automatic int bank_of(input logic [OffW-1:0] off);
    return int'(off[OffW-1:`DCACHE_WORD_OFF_LSB]);
  endfunction

  // high priority requesters mask the rest and the first at or after the pointer wins
  function automatic logic [Ports-1:0] expected_grant(input logic [Ports-1:0] req,
                                                      input logic [Ports-1:0] prio,
                                                      input int ptr);
    logic [Ports-1:0] comp;
    logic [Ports-1:0] gnt;
    int               c;
    comp = ((req & prio) != '0) ? (req & prio) : req;
    gnt  = '0;
    for (int i = Ports - 1; i >= 0; i--) begin
      c = (ptr + i) % Ports;
      if (comp[c]) begin
        gnt    = '0;
        gnt[c] = 1'b1;
      end
    end
    return gnt;
  endfunction

  task automatic check_way_vec(input string what, input logic [Ways-1:0] got,
                               input logic [Ways-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input logic [WordW-1:0] got,
                            input logic [WordW-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ack(input string what, input logic [Ports-1:0] got,
                           input logic [Ports-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic apply_line(input line_wr_t lw);
    int s;
    s = int'(lw.idx);
    for (int w = 0; w < Ways; w++) begin
      if (lw.we[w]) begin
        m_tag[w][s] = lw.tag;
        m_vld[w][s] = lw.vld_bits[w];
        for (int b = 0; b < Banks * BeW; b++) begin
          if (lw.be[b]) begin
            m_data[w][s][b / BeW][(b % BeW) * 8 +: 8] = lw.data[b * 8 +: 8];
          end
        end
      end
    end
  endtask

  task automatic apply_word(input word_wr_t ww);
    int s;
    int k;
    s = int'(ww.idx);
    k = bank_of(ww.off);
    for (int w = 0; w < Ways; w++) begin
      for (int b = 0; b < BeW; b++) begin
        if (ww.req[w] && ww.be[b]) begin
          m_data[w][s][k][b * 8 +: 8] = ww.data[b * 8 +: 8];
        end
      end
    end
  endtask

  task automatic set_read(input int p, input int s, input int way, input int bank,
                          input logic prio, input logic tonly);
    spec_idx[p]   = IdxW'(s);
    spec_off[p]   = OffW'(bank << `DCACHE_WORD_OFF_LSB);
    spec_tag[p]   = m_tag[way][s];
    spec_prio[p]  = prio;
    spec_tonly[p] = tonly;
  endtask

  task automatic set_word_wr(input int s, input int way, input int bank,
                             input logic [BeW-1:0] be);
    spec_wr          = '0;
    spec_wr.req[way] = 1'b1;
    spec_wr.idx      = IdxW'(s);
    spec_wr.off      = OffW'(bank << `DCACHE_WORD_OFF_LSB);
    spec_wr.data     = rand_bits(WordW);
    spec_wr.be       = be;
  endtask

  // compare stage result for a port granted one cycle earlier
  task automatic check_read(input int p);
    logic [Ways-1:0] exp_hit;
    logic [Ways-1:0] exp_vld;
    int              s;
    int              hit_way;
    s       = int'(spec_idx[p]);
    hit_way = -1;
    for (int w = 0; w < Ways; w++) begin
      exp_vld[w] = m_vld[w][s];
      exp_hit[w] = m_vld[w][s] && (m_tag[w][s] == spec_tag[p]);
      if (exp_hit[w]) begin
        hit_way = w;
      end
    end
    check_way_vec($sformatf("hit vector port %0d", p), rd_hit_oh, exp_hit);
    check_way_vec($sformatf("valid bits port %0d", p), rd_vld_bits, exp_vld);
    if (hit_way >= 0 && !spec_tonly[p]) begin
      check_word($sformatf("read data port %0d", p), rd_data,
                 m_data[hit_way][s][bank_of(spec_off[p])]);
    end
  endtask

  ////////////////////
  // drivers
  ////////////////////

  // runs the masked reads until all are granted and checks every grant and result
  // with_wr adds the word write spec in the first cycle
  task automatic run_reads(input logic [Ports-1:0] mask, input bit with_wr);
    logic [Ports-1:0]               pend;
    logic [Ports-1:0]               prio_vec;
    logic [Ports-1:0]               exp_ack;
    logic [Ports-1:0]               req_v;
    logic [Ports-1:0][TagW-1:0]     tag_v;
    rd_port_t [Ports-1:0]           port_v;
    logic                           exp_wr;
    int                             win;
    int                             exp_win;
    int                             prev;
    int                             waited;
    bit                             first;
    pend   = mask;
    req_v  = mask;
    tag_v  = rd_tag;
    prev   = -1;
    waited = 0;
    first  = 1'b1;
    for (int k = 0; k < Ports; k++) begin
      prio_vec[k]          = spec_prio[k];
      port_v[k].idx        = spec_idx[k];
      port_v[k].off        = spec_off[k];
      port_v[k].tag_only   = spec_tonly[k];
      port_v[k].prio       = spec_prio[k];
    end
    @(posedge clk);
    rd_req  <= req_v;
    rd_port <= port_v;
    if (with_wr) begin
      word_wr <= spec_wr;
    end
    forever begin
      @(negedge clk);
      exp_ack = (pend != '0) ? expected_grant(pend, prio_vec, int'(rr_ptr)) : '0;
      check_ack("read grant", rd_ack, exp_ack);
      if (prev >= 0) begin
        check_read(prev);
      end
      win     = -1;
      exp_win = -1;
      for (int k = 0; k < Ports; k++) begin
        if (rd_ack[k]) begin
          win = k;
        end
        if (exp_ack[k]) begin
          exp_win = k;
        end
      end
      if (first && with_wr) begin
        // a word write only yields to a data read of its own bank
        exp_wr = !(exp_win >= 0 && !spec_tonly[exp_win] &&
                   bank_of(spec_off[exp_win]) == bank_of(spec_wr.off));
        check_flag("word write ack", wr_ack, exp_wr);
        if (exp_wr) begin
          apply_word(spec_wr);
        end
      end
      if (pend != '0 && win < 0) begin
        waited++;
        if (waited > RdTimeout) begin
          n_errors++;
          $display("read request on ports %b was not granted within %0d cycles",
                   pend, RdTimeout);
          pend = '0;
        end
      end
      if (pend == '0 && win < 0) begin
        break;
      end
      @(posedge clk);
      word_wr <= '0;
      first = 1'b0;
      prev  = win;
      if (exp_win >= 0) begin
        rr_ptr = (exp_win == Ports - 1) ? 2'd0 : 2'(exp_win + 1);
      end
      if (win >= 0) begin
        req_v[win] = 1'b0;
        tag_v[win] = spec_tag[win];
        pend[win]  = 1'b0;
        rd_req    <= req_v;
        rd_tag    <= tag_v;
      end
    end
    if (rd_req != '0 || word_wr.req != '0) begin
      @(posedge clk);
      rd_req  <= '0;
      word_wr <= '0;
    end
  endtask

  task automatic read_way(input int p, input int s, input int way, input int bank,
                          input logic tonly);
    logic [Ports-1:0] mask;
    mask    = '0;
    mask[p] = 1'b1;
    set_read(p, s, way, bank, 1'b0, tonly);
    run_reads(mask, 1'b0);
  endtask

  // one line write with random data and offset
  // contend adds pending reads and the pending word write spec
  task automatic line_write(input int s, input int way, input logic [TagW-1:0] tag,
                            input logic [Ways-1:0] vld_bits,
                            input logic [Banks*BeW-1:0] be, input bit contend);
    line_wr_t lw;
    lw          = '0;
    lw.vld      = 1'b1;
    lw.we[way]  = 1'b1;
    lw.tag      = tag;
    lw.idx      = IdxW'(s);
    lw.off      = OffW'(rand_bits(OffW));
    lw.data     = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    lw.be       = be;
    lw.vld_bits = vld_bits;
    @(posedge clk);
    line_wr <= lw;
    if (contend) begin
      rd_req  <= '1;
      word_wr <= spec_wr;
    end
    @(negedge clk);
    check_word("refill forward", rd_data, lw.data[bank_of(lw.off) * WordW +: WordW]);
    if (contend) begin
      check_ack("reads during line write", rd_ack, '0);
      check_flag("word write during line write", wr_ack, 1'b0);
    end
    apply_line(lw);
    @(posedge clk);
    line_wr <= '0;
    rd_req  <= '0;
    word_wr <= '0;
    @(negedge clk);
    check_way_vec("hit vector after line write", rd_hit_oh, '0);
  endtask

  task automatic test_begin(input string name);
    test_name      = name;
    test_err_start = n_errors;
    n_tests++;
  endtask

  task automatic test_end();
    if (n_errors == test_err_start) begin
      $display("test %s: ok", test_name);
    end else begin
      n_failed++;
      $display("test %s: failed with %0d errors", test_name, n_errors - test_err_start);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_fill_then_hit();
    int port;
    test_begin("fill_then_hit");
    port = 0;
    foreach (fill_sets[i]) begin
      for (int w = 0; w < Ways; w++) begin
        line_write(fill_sets[i], w, new_tag(w), '1, '1, 1'b0);
      end
    end
    foreach (fill_sets[i]) begin
      for (int w = 0; w < Ways; w++) begin
        for (int b = 0; b < Banks; b++) begin
          read_way(port, fill_sets[i], w, b, 1'b0);
          port = (port + 1) % Ports;
        end
      end
    end
    test_end();
  endtask

  task automatic test_miss_and_invalid();
    test_begin("miss_and_invalid");
    // tag differs from every way in the set
    set_read(0, 3, 0, 1, 1'b0, 1'b0);
    spec_tag[0] = m_tag[0][3] ^ {{(TagW - 2){1'b1}}, 2'b00};
    run_reads(3'b001, 1'b0);
    // way 2 rewritten with its valid bit cleared
    line_write(17, 2, m_tag[2][17], 4'b1011, '1, 1'b0);
    read_way(1, 17, 2, 0, 1'b0);
    read_way(2, 17, 2, 3, 1'b1);
    test_end();
  endtask

  task automatic test_word_write_merge();
    test_begin("word_write_merge");
    set_word_wr(42, 1, 2, 4'b0101);
    run_reads('0, 1'b1);
    read_way(0, 42, 1, 2, 1'b0);
    set_word_wr(63, 3, 0, 4'b1000);
    run_reads('0, 1'b1);
    read_way(2, 63, 3, 0, 1'b0);
    test_end();
  endtask

  task automatic test_arbitration();
    test_begin("arbitration");
    // move the pointer to port 2 before the full round
    read_way(1, 3, 1, 1, 1'b0);
    for (int p = 0; p < Ports; p++) begin
      set_read(p, 3, p, p, 1'b0, 1'b0);
    end
    run_reads('1, 1'b0);
    // port 1 alone at high priority
    for (int p = 0; p < Ports; p++) begin
      set_read(p, 42, p + 1, 3 - p, p == 1, 1'b0);
    end
    run_reads('1, 1'b0);
    set_word_wr(17, 0, 1, 4'b1111);
    line_write(63, 0, new_tag(0), '1, '1, 1'b1);
    read_way(1, 63, 0, 2, 1'b0);
    test_end();
  endtask

  task automatic test_bank_collision();
    test_begin("bank_collision");
    set_read(0, 17, 1, 1, 1'b0, 1'b0);
    set_word_wr(17, 3, 1, 4'b1111);
    run_reads(3'b001, 1'b1);
    set_word_wr(17, 3, 2, 4'b0011);
    run_reads(3'b001, 1'b1);
    read_way(2, 17, 3, 2, 1'b0);
    // tag-only read leaves the data banks free
    set_read(0, 17, 1, 1, 1'b0, 1'b1);
    set_word_wr(17, 3, 1, 4'b1100);
    run_reads(3'b001, 1'b1);
    read_way(1, 17, 3, 1, 1'b0);
    test_end();
  endtask

  task automatic test_refill_forwarding();
    test_begin("refill_forwarding");
    for (int w = 0; w < Ways; w++) begin
      line_write(50, w, new_tag(w), '1, '1, 1'b0);
    end
    // partial byte enables keep part of the old line
    for (int w = 0; w < Ways; w++) begin
      line_write(50, w, m_tag[w][50], '1, 16'(rand_bits(16)), 1'b0);
    end
    for (int b = 0; b < Banks; b++) begin
      read_way(b % Ports, 50, 2, b, 1'b0);
    end
    test_end();
  endtask

  ////////////////////
  // main and watchdog
  ////////////////////

  initial begin : p_main
    lfsr_q = 32'd97305;
    rr_ptr = 2'd0;
    rst_n   <= 1'b0;
    rd_req  <= '0;
    rd_port <= '0;
    rd_tag  <= '0;
    line_wr <= '0;
    word_wr <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    test_fill_then_hit();
    test_miss_and_invalid();
    test_word_write_merge();
    test_arbitration();
    test_bank_collision();
    test_refill_forwarding();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : p_watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired after %0d cycles before the tests completed", WatchdogCycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_rr_arbiter.sv
rtl/dcache_sram.sv
rtl/dcache_bank_ctrl.sv
rtl/dcache_hit_sel.sv
rtl/dcache_mem.sv
dv/tb_clkgen.sv
dv/tb_dcache_mem.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f project.f \
  --top-module tb_dcache_mem -Mdir obj_dir -o tb_dcache_mem
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/tb_dcache_mem > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "pass message not found in sim.log"
exit 1
